//--- fuzzy_irrigation.f
+incdir+verif
src/irrigation_pkg.sv
src/adc_scaler.sv
src/threshold_regs.sv
src/fuzzifier.sv
src/fuzzy_inference.sv
src/pump_controller.sv
src/irrigation_top.sv
verif/irrigation_tb.sv

//--- verif/irrigation_model.svh
`ifndef IRRIGATION_MODEL_SVH
`define IRRIGATION_MODEL_SVH

// Millivolts to a 10-bit code, saturating at full scale
function automatic irrigation_pkg::sensor_t scale_mv(input irrigation_pkg::mv_t mv);
    int code;
    code = int'(mv) * irrigation_pkg::CODE_MAX / irrigation_pkg::VREF_MV;
    if (code > irrigation_pkg::CODE_MAX) begin
        code = irrigation_pkg::CODE_MAX;
    end
    return irrigation_pkg::sensor_t'(code);
endfunction

// Degree rising from 0 at lo to full at hi
function automatic int ramp_up(input int x, input int lo, input int hi);
    if (x <= lo) return 0;
    if (x >= hi) return int'(irrigation_pkg::MU_ONE);
    return (x - lo) * int'(irrigation_pkg::MU_ONE) / (hi - lo);
endfunction

// Degree falling from full at lo to 0 at hi
function automatic int ramp_down(input int x, input int lo, input int hi);
    if (x <= lo) return int'(irrigation_pkg::MU_ONE);
    if (x >= hi) return 0;
    return (hi - x) * int'(irrigation_pkg::MU_ONE) / (hi - lo);
endfunction

// Ordering rule for a threshold write, indices as on the APB
function automatic bit write_allowed(input int idx, input irrigation_pkg::sensor_t data,
                                     input irrigation_pkg::sensor_t thr [8]);
    bit first;
    bit last;
    first = (idx == 0 || idx == 3 || idx == 6);
    last  = (idx == 2 || idx == 5 || idx == 7);
    return (data != 0) && (first || data > thr[idx - 1]) && (last || data < thr[idx + 1]);
endfunction

// Min inference and weighted average over the rule table
function automatic irrigation_pkg::irr_time_t model_time(input int s, input int t, input int r,
                                                        input irrigation_pkg::sensor_t thr [8]);
    int soil_mu [3];
    int temp_mu [3];
    int rain_mu [2];
    int w;
    int num;
    int den;
    soil_mu[0] = ramp_down(s, thr[0], thr[1]);
    soil_mu[1] = (s <= thr[1]) ? ramp_up(s, thr[0], thr[1]) : ramp_down(s, thr[1], thr[2]);
    soil_mu[2] = ramp_up(s, thr[1], thr[2]);
    temp_mu[0] = ramp_down(t, thr[3], thr[4]);
    temp_mu[1] = (t <= thr[4]) ? ramp_up(t, thr[3], thr[4]) : ramp_down(t, thr[4], thr[5]);
    temp_mu[2] = ramp_up(t, thr[4], thr[5]);
    rain_mu[0] = ramp_down(r, thr[6], thr[7]);
    rain_mu[1] = ramp_up(r, thr[6], thr[7]);
    num = 0;
    den = 0;
    for (int si = 0; si < 3; si++) begin
        for (int ti = 0; ti < 3; ti++) begin
            for (int ri = 0; ri < 2; ri++) begin
                w = soil_mu[si];
                if (temp_mu[ti] < w) w = temp_mu[ti];
                if (rain_mu[ri] < w) w = rain_mu[ri];
                num = num + w * int'(irrigation_pkg::RULE_TIME[si * 6 + ti * 2 + ri]);
                den = den + w;
            end
        end
    end
    return (den == 0) ? '0 : irrigation_pkg::irr_time_t'(num / den);
endfunction

`endif

//--- verif/irrigation_tb.sv
module irrigation_tb;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_RANDOM = 12;
    localparam int WAIT_LIMIT = 64;      // Longest single wait in cycles
    // APB tests, then every sample test bounded by its two waits
    localparam int RUN_CYCLES = 4 + 2 * 8 * 3 + (NUM_RANDOM + 4) * (2 * WAIT_LIMIT + 16) + 200;

    logic                      clk;
    logic                      reset;
    irrigation_pkg::mv_t       soil_mv;
    irrigation_pkg::mv_t       temp_mv;
    irrigation_pkg::mv_t       rain_mv;
    logic                      sample;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [4:0]                paddr;
    irrigation_pkg::sensor_t   pwdata;
    irrigation_pkg::sensor_t   prdata;
    logic                      pslverr;
    logic                      decision_valid;
    irrigation_pkg::irr_time_t irrigation_time;
    logic                      rain_present;
    logic                      pump_on;
    logic                      sensing_enabled;
    irrigation_pkg::irr_time_t watering_timer;

    irrigation_pkg::sensor_t   thr_copy [8];
    irrigation_pkg::irr_time_t exp_time_q [$];
    logic                      exp_rain_q [$];
    irrigation_pkg::irr_time_t exp_time;
    irrigation_pkg::irr_time_t exp_left;  // Watering cycles still due
    logic                      exp_rain;
    logic                      exp_err;
    irrigation_pkg::sensor_t   exp_rdata;
    logic [3:0]                acc_pipe;  // Accepted samples, newest in bit 0
    logic                      accepted;
    int                        seed = 32'h682f;
    int                        errors;
    int                        err_mark;
    int                        tests_run;
    int                        tests_failed;
    string                     test_name = "reset";

    `include "irrigation_model.svh"

    irrigation_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    assign accepted = sample && (exp_left == '0);

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_pipe <= '0;
            exp_left <= '0;
        end else begin
            acc_pipe <= {acc_pipe[2:0], accepted};
            if (exp_left != '0) begin
                exp_left <= exp_left - 1'b1;
            end else if (decision_valid && exp_time != '0) begin
                exp_left <= exp_time;  // Pump loads on the edge after a decision
            end
            if (accepted) begin
                exp_time_q.push_back(model_time(scale_mv(soil_mv), scale_mv(temp_mv),
                                                scale_mv(rain_mv), thr_copy));
                exp_rain_q.push_back(scale_mv(rain_mv) >= thr_copy[7]);
            end
        end
    end

    // Expected decision is ready well before the checking edge
    always @(negedge clk) begin
        if (!reset && decision_valid) begin
            if (exp_time_q.size() == 0) begin
                errors++;
                $display("%s: decision_valid with no accepted sample pending", test_name);
            end else begin
                exp_time = exp_time_q.pop_front();
                exp_rain = exp_rain_q.pop_front();
            end
        end
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        errors++;
        $display("FAILED %s %s expected %0d actual %0d", test_name, what, expected, actual);
    endtask

    a_timing: assert property (@(posedge clk) disable iff (reset) decision_valid == acc_pipe[3])
        else report_mismatch("decision_valid", $sampled(acc_pipe[3]), $sampled(decision_valid));
    a_time: assert property (@(posedge clk) disable iff (reset)
                             decision_valid |-> irrigation_time == exp_time)
        else report_mismatch("irrigation_time", $sampled(exp_time), $sampled(irrigation_time));
    a_rain: assert property (@(posedge clk) disable iff (reset)
                             decision_valid |-> rain_present == exp_rain)
        else report_mismatch("rain_present", $sampled(exp_rain), $sampled(rain_present));
    a_pump: assert property (@(posedge clk) disable iff (reset) pump_on == (exp_left != '0))
        else report_mismatch("pump_on", $sampled(exp_left != '0), $sampled(pump_on));
    a_timer: assert property (@(posedge clk) disable iff (reset) watering_timer == exp_left)
        else report_mismatch("watering_timer", $sampled(exp_left), $sampled(watering_timer));
    a_sensing: assert property (@(posedge clk) disable iff (reset)
                                sensing_enabled == (exp_left == '0))
        else report_mismatch("sensing_enabled", $sampled(exp_left == '0),
                             $sampled(sensing_enabled));
    a_slverr: assert property (@(posedge clk) disable iff (reset)
                               pslverr == (psel && penable && exp_err))
        else report_mismatch("pslverr", $sampled(psel && penable && exp_err), $sampled(pslverr));
    a_rdata: assert property (@(posedge clk) disable iff (reset)
                              (psel && penable && !pwrite) |-> prdata == exp_rdata)
        else report_mismatch("prdata", $sampled(exp_rdata), $sampled(prdata));

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, errors - err_mark);
        end
    endtask

    // Setup and access phase, no wait states
    task automatic apb_access(input logic wr, input logic [4:0] addr,
                              input irrigation_pkg::sensor_t data);
        int idx;
        bit ok;
        idx = addr[4:2];
        ok  = (addr[1:0] == 2'b00) && (!wr || write_allowed(idx, data, thr_copy));
        @(posedge clk);
        psel      <= 1'b1;
        penable   <= 1'b0;
        pwrite    <= wr;
        paddr     <= addr;
        pwdata    <= data;
        exp_err   <= !ok;
        exp_rdata <= (ok && !wr) ? thr_copy[idx] : '0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (ok && wr) thr_copy[idx] = data;
    endtask

    function automatic irrigation_pkg::mv_t rand_mv();
        return irrigation_pkg::mv_t'($unsigned($random(seed)) % (irrigation_pkg::VREF_MV + 1));
    endfunction

    task automatic offer_sample(input int soil, input int temp, input int rain);
        @(posedge clk);
        soil_mv <= irrigation_pkg::mv_t'(soil);
        temp_mv <= irrigation_pkg::mv_t'(temp);
        rain_mv <= irrigation_pkg::mv_t'(rain);
        sample  <= 1'b1;
        @(posedge clk);
        sample <= 1'b0;
    endtask

    task automatic wait_decision();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!decision_valid && n < WAIT_LIMIT);
        if (!decision_valid) begin
            errors++;
            $display("%s: no decision_valid within %0d cycles", test_name, WAIT_LIMIT);
        end
    endtask

    task automatic wait_pump_idle();
        int n;
        n = 0;
        repeat (6) @(posedge clk);  // Let decisions in flight reach the pump
        while (pump_on && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (pump_on) begin
            errors++;
            $display("%s: pump still on after %0d cycles", test_name, WAIT_LIMIT);
        end
    endtask

    initial begin
        reset     <= 1'b1;
        sample    <= 1'b0;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        paddr     <= '0;
        pwdata    <= '0;
        soil_mv   <= '0;
        temp_mv   <= '0;
        rain_mv   <= '0;
        exp_err   <= 1'b0;
        exp_rdata <= '0;
        thr_copy = '{irrigation_pkg::DEF_SOIL_DRY, irrigation_pkg::DEF_SOIL_MOIST,
                     irrigation_pkg::DEF_SOIL_WET, irrigation_pkg::DEF_TEMP_COLD,
                     irrigation_pkg::DEF_TEMP_WARM, irrigation_pkg::DEF_TEMP_HOT,
                     irrigation_pkg::DEF_RAIN_NO, irrigation_pkg::DEF_RAIN_YES};
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        begin_test("reset_defaults");
        for (int i = 0; i < 8; i++) begin
            apb_access(1'b0, 5'(i * 4), '0);
        end
        end_test();

        begin_test("threshold_writes");
        apb_access(1'b1, 5'h04, 10'd650);
        apb_access(1'b0, 5'h04, '0);
        apb_access(1'b1, 5'h04, 10'd800);   // Not below soil_wet
        apb_access(1'b0, 5'h04, '0);
        apb_access(1'b1, 5'h0c, 10'd0);
        apb_access(1'b0, 5'h0c, '0);
        apb_access(1'b1, 5'h15, 10'd650);   // Unaligned, no register behind it
        apb_access(1'b0, 5'h15, '0);
        end_test();

        begin_test("decision_timing");
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            soil_mv <= rand_mv();
            temp_mv <= rand_mv();
            rain_mv <= rand_mv();
            sample  <= 1'b1;
        end
        @(posedge clk);
        sample <= 1'b0;
        wait_decision();
        wait_pump_idle();
        end_test();

        begin_test("decision_values");
        offer_sample(0, irrigation_pkg::VREF_MV, 0);
        wait_decision();
        assert (irrigation_time == 8'd45)
            else report_mismatch("corner irrigation_time", 45, irrigation_time);
        assert (rain_present == 1'b0)
            else report_mismatch("corner rain_present", 0, rain_present);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            wait_pump_idle();
            offer_sample(rand_mv(), rand_mv(), rand_mv());
            wait_decision();
        end
        end_test();

        begin_test("pump_control");
        wait_pump_idle();
        offer_sample(0, irrigation_pkg::VREF_MV, 0);
        wait_decision();
        repeat (3) @(posedge clk);
        repeat (4) offer_sample(rand_mv(), rand_mv(), rand_mv());  // Dropped while watering
        wait_pump_idle();
        offer_sample(irrigation_pkg::VREF_MV, 0, 0);                // Wet and cold, zero time
        wait_decision();
        repeat (4) @(posedge clk);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", RUN_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- src/irrigation_top.sv
module irrigation_top (
    input  logic                      clk,
    input  logic                      reset,
    input  irrigation_pkg::mv_t       soil_mv,
    input  irrigation_pkg::mv_t       temp_mv,
    input  irrigation_pkg::mv_t       rain_mv,
    input  logic                      sample,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [4:0]                paddr,
    input  irrigation_pkg::sensor_t   pwdata,
    output irrigation_pkg::sensor_t   prdata,
    output logic                      pslverr,
    output logic                      decision_valid,
    output irrigation_pkg::irr_time_t irrigation_time,
    output logic                      rain_present,
    output logic                      pump_on,
    output logic                      sensing_enabled,
    output irrigation_pkg::irr_time_t watering_timer
);

    irrigation_pkg::sensor_t soil_code;
    irrigation_pkg::sensor_t temp_code;
    irrigation_pkg::sensor_t rain_code;
    logic                    code_valid;
    irrigation_pkg::sensor_t soil_dry;
    irrigation_pkg::sensor_t soil_moist;
    irrigation_pkg::sensor_t soil_wet;
    irrigation_pkg::sensor_t temp_cold;
    irrigation_pkg::sensor_t temp_warm;
    irrigation_pkg::sensor_t temp_hot;
    irrigation_pkg::sensor_t rain_no;
    irrigation_pkg::sensor_t rain_yes;
    irrigation_pkg::mu_t     mu_soil_dry;
    irrigation_pkg::mu_t     mu_soil_moist;
    irrigation_pkg::mu_t     mu_soil_wet;
    irrigation_pkg::mu_t     mu_temp_cold;
    irrigation_pkg::mu_t     mu_temp_warm;
    irrigation_pkg::mu_t     mu_temp_hot;
    irrigation_pkg::mu_t     mu_rain_no;
    irrigation_pkg::mu_t     mu_rain_yes;
    logic                    mu_valid;
    logic                    rain_flag;

    adc_scaler u_adc (
        .clk, .reset,
        .soil_mv, .temp_mv, .rain_mv,
        .sample, .sensing_enabled,
        .soil_code, .temp_code, .rain_code,
        .code_valid
    );

    threshold_regs u_thr (
        .clk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pslverr,
        .soil_dry, .soil_moist, .soil_wet,
        .temp_cold, .temp_warm, .temp_hot,
        .rain_no, .rain_yes
    );

    fuzzifier u_fuzz (
        .clk, .reset,
        .soil_code, .temp_code, .rain_code, .code_valid,
        .soil_dry, .soil_moist, .soil_wet,
        .temp_cold, .temp_warm, .temp_hot,
        .rain_no, .rain_yes,
        .mu_soil_dry, .mu_soil_moist, .mu_soil_wet,
        .mu_temp_cold, .mu_temp_warm, .mu_temp_hot,
        .mu_rain_no, .mu_rain_yes,
        .mu_valid, .rain_flag
    );

    fuzzy_inference u_infer (
        .clk, .reset,
        .mu_soil_dry, .mu_soil_moist, .mu_soil_wet,
        .mu_temp_cold, .mu_temp_warm, .mu_temp_hot,
        .mu_rain_no, .mu_rain_yes,
        .mu_valid, .rain_flag,
        .irrigation_time, .rain_present, .decision_valid
    );

    pump_controller u_pump (
        .clk, .reset,
        .irrigation_time, .decision_valid,
        .pump_on, .sensing_enabled, .watering_timer
    );

endmodule

//--- src/pump_controller.sv
module pump_controller (
    input  logic                      clk,
    input  logic                      reset,
    input  irrigation_pkg::irr_time_t irrigation_time,
    input  logic                      decision_valid,
    output logic                      pump_on,
    output logic                      sensing_enabled,
    output irrigation_pkg::irr_time_t watering_timer
);

    irrigation_pkg::pump_state_e state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= irrigation_pkg::PUMP_IDLE;
            watering_timer <= '0;
        end else begin
            case (state)
                irrigation_pkg::PUMP_IDLE: begin
                    if (decision_valid && irrigation_time != '0) begin
                        state          <= irrigation_pkg::PUMP_WATERING;
                        watering_timer <= irrigation_time;
                    end
                end
                irrigation_pkg::PUMP_WATERING: begin
                    // Later decisions are ignored until the count runs out
                    watering_timer <= watering_timer - 1'b1;
                    if (watering_timer == 8'd1) begin
                        state <= irrigation_pkg::PUMP_IDLE;
                    end
                end
                default: begin
                    state <= irrigation_pkg::PUMP_IDLE;
                end
            endcase
        end
    end

    assign pump_on         = (state == irrigation_pkg::PUMP_WATERING);
    assign sensing_enabled = !pump_on;       // No sampling while watering

endmodule

//--- src/fuzzy_inference.sv
module fuzzy_inference (
    input  logic                      clk,
    input  logic                      reset,
    input  irrigation_pkg::mu_t       mu_soil_dry,
    input  irrigation_pkg::mu_t       mu_soil_moist,
    input  irrigation_pkg::mu_t       mu_soil_wet,
    input  irrigation_pkg::mu_t       mu_temp_cold,
    input  irrigation_pkg::mu_t       mu_temp_warm,
    input  irrigation_pkg::mu_t       mu_temp_hot,
    input  irrigation_pkg::mu_t       mu_rain_no,
    input  irrigation_pkg::mu_t       mu_rain_yes,
    input  logic                      mu_valid,
    input  logic                      rain_flag,
    output irrigation_pkg::irr_time_t irrigation_time,
    output logic                      rain_present,
    output logic                      decision_valid
);

    irrigation_pkg::mu_t  soil_mu [3];
    irrigation_pkg::mu_t  temp_mu [3];
    irrigation_pkg::mu_t  rain_mu [2];
    irrigation_pkg::mu_t  strength [irrigation_pkg::NUM_RULES];
    irrigation_pkg::acc_t num_sum;
    irrigation_pkg::acc_t den_sum;
    irrigation_pkg::acc_t num_q;
    irrigation_pkg::acc_t den_q;
    logic                 s1_valid;
    logic                 s1_rain;

    function automatic irrigation_pkg::mu_t min3(input irrigation_pkg::mu_t a,
                                                 input irrigation_pkg::mu_t b,
                                                 input irrigation_pkg::mu_t c);
        irrigation_pkg::mu_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    assign soil_mu = '{mu_soil_dry, mu_soil_moist, mu_soil_wet};
    assign temp_mu = '{mu_temp_cold, mu_temp_warm, mu_temp_hot};
    assign rain_mu = '{mu_rain_no, mu_rain_yes};

    // Min inference over all soil, temp and rain combinations
    always_comb begin
        num_sum = '0;
        den_sum = '0;
        for (int i = 0; i < irrigation_pkg::NUM_RULES; i++) begin
            strength[i] = min3(soil_mu[i / 6], temp_mu[(i / 2) % 3], rain_mu[i % 2]);
            num_sum = num_sum + strength[i] * irrigation_pkg::RULE_TIME[i];
            den_sum = den_sum + strength[i];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid        <= 1'b0;
            decision_valid  <= 1'b0;
            irrigation_time <= '0;
            rain_present    <= 1'b0;
        end else begin
            s1_valid       <= mu_valid;
            decision_valid <= s1_valid;
            if (s1_valid) begin                 // Outputs hold until the next decision
                irrigation_time <= (den_q == '0) ? '0 : irrigation_pkg::irr_time_t'(num_q / den_q);
                rain_present    <= s1_rain;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mu_valid) begin
            num_q   <= num_sum;
            den_q   <= den_sum;
            s1_rain <= rain_flag;
        end
    end

endmodule

//--- src/fuzzifier.sv
module fuzzifier (
    input  logic                    clk,
    input  logic                    reset,
    input  irrigation_pkg::sensor_t soil_code,
    input  irrigation_pkg::sensor_t temp_code,
    input  irrigation_pkg::sensor_t rain_code,
    input  logic                    code_valid,
    input  irrigation_pkg::sensor_t soil_dry,
    input  irrigation_pkg::sensor_t soil_moist,
    input  irrigation_pkg::sensor_t soil_wet,
    input  irrigation_pkg::sensor_t temp_cold,
    input  irrigation_pkg::sensor_t temp_warm,
    input  irrigation_pkg::sensor_t temp_hot,
    input  irrigation_pkg::sensor_t rain_no,
    input  irrigation_pkg::sensor_t rain_yes,
    output irrigation_pkg::mu_t     mu_soil_dry,
    output irrigation_pkg::mu_t     mu_soil_moist,
    output irrigation_pkg::mu_t     mu_soil_wet,
    output irrigation_pkg::mu_t     mu_temp_cold,
    output irrigation_pkg::mu_t     mu_temp_warm,
    output irrigation_pkg::mu_t     mu_temp_hot,
    output irrigation_pkg::mu_t     mu_rain_no,
    output irrigation_pkg::mu_t     mu_rain_yes,
    output logic                    mu_valid,
    output logic                    rain_flag
);

    // Distance over span scaled to MU_ONE, truncating
    function automatic irrigation_pkg::mu_t frac(input irrigation_pkg::sensor_t num,
                                                 input irrigation_pkg::sensor_t span);
        logic [2*irrigation_pkg::SENSOR_W-1:0] prod;
        prod = num * irrigation_pkg::MU_ONE;
        return irrigation_pkg::mu_t'(prod / span);
    endfunction

    // Two sets crossing between lo and hi, returns {low, high}
    function automatic logic [2*irrigation_pkg::SENSOR_W-1:0] member2(
        input irrigation_pkg::sensor_t x,
        input irrigation_pkg::sensor_t lo,
        input irrigation_pkg::sensor_t hi
    );
        if (x <= lo) begin
            return {irrigation_pkg::MU_ONE, irrigation_pkg::mu_t'(0)};
        end else if (x <= hi) begin
            return {frac(hi - x, hi - lo), frac(x - lo, hi - lo)};
        end
        return {irrigation_pkg::mu_t'(0), irrigation_pkg::MU_ONE};
    endfunction

    // Three sets, returns {low, mid, high}
    function automatic logic [3*irrigation_pkg::SENSOR_W-1:0] member3(
        input irrigation_pkg::sensor_t x,
        input irrigation_pkg::sensor_t lo,
        input irrigation_pkg::sensor_t mid,
        input irrigation_pkg::sensor_t hi
    );
        if (x <= mid) begin
            return {member2(x, lo, mid), irrigation_pkg::mu_t'(0)};
        end
        return {irrigation_pkg::mu_t'(0), member2(x, mid, hi)};
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mu_valid <= 1'b0;
        end else begin
            mu_valid <= code_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (code_valid) begin
            {mu_soil_dry, mu_soil_moist, mu_soil_wet} <=
                member3(soil_code, soil_dry, soil_moist, soil_wet);
            {mu_temp_cold, mu_temp_warm, mu_temp_hot} <=
                member3(temp_code, temp_cold, temp_warm, temp_hot);
            {mu_rain_no, mu_rain_yes} <= member2(rain_code, rain_no, rain_yes);
            rain_flag <= (rain_code >= rain_yes);   // Crisp rain detection
        end
    end

endmodule

//--- src/threshold_regs.sv
module threshold_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [4:0]              paddr,
    input  irrigation_pkg::sensor_t pwdata,
    output irrigation_pkg::sensor_t prdata,
    output logic                    pslverr,
    output irrigation_pkg::sensor_t soil_dry,
    output irrigation_pkg::sensor_t soil_moist,
    output irrigation_pkg::sensor_t soil_wet,
    output irrigation_pkg::sensor_t temp_cold,
    output irrigation_pkg::sensor_t temp_warm,
    output irrigation_pkg::sensor_t temp_hot,
    output irrigation_pkg::sensor_t rain_no,
    output irrigation_pkg::sensor_t rain_yes
);

    irrigation_pkg::sensor_t  thr [8];
    irrigation_pkg::thr_sel_e sel;
    logic [2:0]               idx_lo;
    logic [2:0]               idx_hi;
    logic                     access;
    logic                     addr_ok;
    logic                     has_lo;
    logic                     has_hi;
    logic                     wr_ok;

    assign access  = psel && penable;             // Access phase, no wait states
    assign addr_ok = (paddr[1:0] == 2'b00);       // Unaligned addresses hit no register
    assign sel     = irrigation_pkg::thr_sel_e'(paddr[4:2]);
    assign idx_lo  = paddr[4:2] - 3'd1;
    assign idx_hi  = paddr[4:2] + 3'd1;

    // First and last threshold of a group have a single neighbour
    assign has_lo = !(sel inside {irrigation_pkg::THR_SOIL_DRY, irrigation_pkg::THR_TEMP_COLD,
                                  irrigation_pkg::THR_RAIN_NO});
    assign has_hi = !(sel inside {irrigation_pkg::THR_SOIL_WET, irrigation_pkg::THR_TEMP_HOT,
                                  irrigation_pkg::THR_RAIN_YES});

    assign wr_ok = (pwdata != '0)
                && (!has_lo || pwdata > thr[idx_lo])
                && (!has_hi || pwdata < thr[idx_hi]);

    assign pslverr = access && (!addr_ok || (pwrite && !wr_ok));
    assign prdata  = (access && !pwrite && addr_ok) ? thr[sel] : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            thr[irrigation_pkg::THR_SOIL_DRY]   <= irrigation_pkg::DEF_SOIL_DRY;
            thr[irrigation_pkg::THR_SOIL_MOIST] <= irrigation_pkg::DEF_SOIL_MOIST;
            thr[irrigation_pkg::THR_SOIL_WET]   <= irrigation_pkg::DEF_SOIL_WET;
            thr[irrigation_pkg::THR_TEMP_COLD]  <= irrigation_pkg::DEF_TEMP_COLD;
            thr[irrigation_pkg::THR_TEMP_WARM]  <= irrigation_pkg::DEF_TEMP_WARM;
            thr[irrigation_pkg::THR_TEMP_HOT]   <= irrigation_pkg::DEF_TEMP_HOT;
            thr[irrigation_pkg::THR_RAIN_NO]    <= irrigation_pkg::DEF_RAIN_NO;
            thr[irrigation_pkg::THR_RAIN_YES]   <= irrigation_pkg::DEF_RAIN_YES;
        end else if (access && pwrite && !pslverr) begin
            thr[sel] <= pwdata;
        end
    end

    assign soil_dry   = thr[irrigation_pkg::THR_SOIL_DRY];
    assign soil_moist = thr[irrigation_pkg::THR_SOIL_MOIST];
    assign soil_wet   = thr[irrigation_pkg::THR_SOIL_WET];
    assign temp_cold  = thr[irrigation_pkg::THR_TEMP_COLD];
    assign temp_warm  = thr[irrigation_pkg::THR_TEMP_WARM];
    assign temp_hot   = thr[irrigation_pkg::THR_TEMP_HOT];
    assign rain_no    = thr[irrigation_pkg::THR_RAIN_NO];
    assign rain_yes   = thr[irrigation_pkg::THR_RAIN_YES];

endmodule

//--- src/adc_scaler.sv
module adc_scaler (
    input  logic                    clk,
    input  logic                    reset,
    input  irrigation_pkg::mv_t     soil_mv,
    input  irrigation_pkg::mv_t     temp_mv,
    input  irrigation_pkg::mv_t     rain_mv,
    input  logic                    sample,
    input  logic                    sensing_enabled,
    output irrigation_pkg::sensor_t soil_code,
    output irrigation_pkg::sensor_t temp_code,
    output irrigation_pkg::sensor_t rain_code,
    output logic                    code_valid
);

    logic take;

    // Millivolts to code, clipped at full scale
    function automatic irrigation_pkg::sensor_t scale(input irrigation_pkg::mv_t mv);
        logic [31:0] q;
        q = (32'(mv) * irrigation_pkg::CODE_MAX) / irrigation_pkg::VREF_MV;
        return irrigation_pkg::sensor_t'((q > irrigation_pkg::CODE_MAX) ?
                                         irrigation_pkg::CODE_MAX : q);
    endfunction

    assign take = sample && sensing_enabled;    // Strobes while watering are lost

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            code_valid <= 1'b0;
        end else begin
            code_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            soil_code <= scale(soil_mv);
            temp_code <= scale(temp_mv);
            rain_code <= scale(rain_mv);
        end
    end

endmodule

//--- src/irrigation_pkg.sv
package irrigation_pkg;

    localparam int SENSOR_W = 10;
    localparam int MV_W     = 16;
    localparam int TIME_W   = 8;
    localparam int ACC_W    = 18;

    typedef logic [SENSOR_W-1:0] sensor_t;    // Sensor code or threshold
    typedef logic [MV_W-1:0]     mv_t;        // Millivolts
    typedef logic [SENSOR_W-1:0] mu_t;        // Membership degree
    typedef logic [TIME_W-1:0]   irr_time_t;  // Irrigation time in cycles
    typedef logic [ACC_W-1:0]    acc_t;       // Defuzzifier sums

    localparam mu_t MU_ONE   = 10'd1023;      // Full membership
    localparam int  VREF_MV  = 5000;
    localparam int  CODE_MAX = 1023;

    localparam sensor_t DEF_SOIL_DRY   = 10'd400;
    localparam sensor_t DEF_SOIL_MOIST = 10'd600;
    localparam sensor_t DEF_SOIL_WET   = 10'd800;
    localparam sensor_t DEF_TEMP_COLD  = 10'd300;
    localparam sensor_t DEF_TEMP_WARM  = 10'd500;
    localparam sensor_t DEF_TEMP_HOT   = 10'd700;
    localparam sensor_t DEF_RAIN_NO    = 10'd100;
    localparam sensor_t DEF_RAIN_YES   = 10'd400;

    localparam int NUM_RULES = 18;

    // Rule index is soil*6 + temp*2 + rain
    localparam irr_time_t RULE_TIME [NUM_RULES] = '{
        8'd0, 8'd0, 8'd10, 8'd0, 8'd45, 8'd0,   // Dry soil
        8'd0, 8'd0, 8'd10, 8'd0, 8'd45, 8'd0,   // Moist soil
        8'd0, 8'd0, 8'd10, 8'd0, 8'd30, 8'd0    // Wet soil
    };

    // Value is the APB word index
    typedef enum logic [2:0] {
        THR_SOIL_DRY,
        THR_SOIL_MOIST,
        THR_SOIL_WET,
        THR_TEMP_COLD,
        THR_TEMP_WARM,
        THR_TEMP_HOT,
        THR_RAIN_NO,
        THR_RAIN_YES
    } thr_sel_e;

    typedef enum logic {
        PUMP_IDLE,
        PUMP_WATERING
    } pump_state_e;

endpackage
